// File: Bender.yml
package:
  name: ooo_core

sources:
  - verilog/core_pkg.sv
  - verilog/rename_table.sv
  - verilog/reorder_buffer.sv
  - verilog/reservation_station.sv
  - verilog/alu_unit.sv
  - verilog/muldiv_unit.sv
  - verilog/cdb_arbiter.sv
  - verilog/ooo_core.sv
  - target: test
    files:
      - verification/tb_ooo_core.sv

// File: project.f
verilog/core_pkg.sv
verilog/rename_table.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/muldiv_unit.sv
verilog/cdb_arbiter.sv
verilog/ooo_core.sv
verification/tb_ooo_core.sv

// File: verification/tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;
    import core_pkg::*;

    // 11 muldiv ops at about 36 cycles each plus ALU traffic stays under 600 cycles
    localparam int MAX_CYCLES = 4000;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    commit_t   commit;

    word_t     ref_regs [32];  // architectural state in program order
    reg_addr_t exp_rd [$];
    word_t     exp_val [$];
    string     test_name;
    int        errors;
    int        commits;
    int        stalls;
    int        cycles;
    integer    seed;

    ooo_core #(.ALU_RS_DEPTH(4), .MULDIV_RS_DEPTH(2)) dut (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .dispatch_ready(dispatch_ready), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t alu_model(input logic [2:0] op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic word_t muldiv_model(input logic [1:0] op, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            MD_MUL:   return prod[31:0];
            MD_MULHU: return prod[63:32];
            MD_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            default:  return (b == 0) ? a : a % b;
        endcase
    endfunction

    // called at a falling edge, returns at the falling edge after acceptance
    task send(input unit_e unit, input logic [2:0] op, input reg_addr_t rd, input reg_addr_t rs1,
              input reg_addr_t rs2, input logic use_imm, input word_t imm);
        word_t a;
        word_t b;
        word_t res;
        a = ref_regs[rs1];
        b = use_imm ? imm : ref_regs[rs2];
        res = (unit == UNIT_ALU) ? alu_model(op, a, b) : muldiv_model(op[1:0], a, b);
        exp_rd.push_back(rd);
        exp_val.push_back(res);
        if (rd != 0) begin
            ref_regs[rd] = res;
        end
        dispatch = '{unit: unit, op: op, rd: rd, rs1: rs1, rs2: rs2, use_imm: use_imm, imm: imm};
        dispatch_valid = 1'b1;
        #1;
        while (!dispatch_ready) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task drain;
        while (exp_rd.size() != 0) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!rst && commit.valid) begin
            commits++;
            if (exp_rd.size() == 0) begin
                errors++;
                $display("%s: commit to x%0d with no dispatch outstanding", test_name, commit.rd);
            end else begin
                if (commit.rd != exp_rd[0] || commit.value != exp_val[0]) begin
                    errors++;
                    $display("** Error %s: expected x%0d=%h, actual x%0d=%h",
                             test_name, exp_rd[0], exp_val[0], commit.rd, commit.value);
                end
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d commits outstanding", cycles, exp_rd.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    task test_alu_imm;
        word_t imm;
        test_name = "alu_imm";
        send(UNIT_ALU, ALU_ADD, 5'd1, 5'd0, 5'd0, 1'b1, $random(seed));
        send(UNIT_ALU, ALU_ADD, 5'd2, 5'd0, 5'd0, 1'b1, $random(seed));
        drain();
        for (int op = 0; op < 8; op++) begin
            imm = $random(seed);
            send(UNIT_ALU, 3'(op), reg_addr_t'(3 + op), 5'd1, 5'd0, 1'b1, imm);
        end
        drain();
    endtask

    task test_dep_chain;
        test_name = "dep_chain";
        for (int i = 0; i < 12; i++) begin // each op reads the previous one
            send(UNIT_ALU, 3'(i % 8), reg_addr_t'(10 + i % 3), reg_addr_t'(10 + (i + 2) % 3),
                 (i == 0) ? 5'd1 : reg_addr_t'(10 + (i + 1) % 3), (i % 3) == 2, $random(seed));
        end
        drain();
    endtask

    task test_muldiv;
        test_name = "muldiv";
        send(UNIT_ALU, ALU_ADD, 5'd20, 5'd0, 5'd0, 1'b1, $random(seed));
        send(UNIT_ALU, ALU_ADD, 5'd21, 5'd0, 5'd0, 1'b1, $random(seed));
        send(UNIT_ALU, ALU_SRL, 5'd19, 5'd21, 5'd0, 1'b1, 32'd12); // smaller divisor
        send(UNIT_MULDIV, MD_MUL, 5'd22, 5'd20, 5'd21, 1'b0, '0);
        send(UNIT_MULDIV, MD_MULHU, 5'd23, 5'd20, 5'd21, 1'b0, '0);
        send(UNIT_MULDIV, MD_DIVU, 5'd24, 5'd20, 5'd19, 1'b0, '0);
        send(UNIT_MULDIV, MD_REMU, 5'd25, 5'd20, 5'd19, 1'b0, '0);
        send(UNIT_MULDIV, MD_DIVU, 5'd26, 5'd20, 5'd0, 1'b0, '0); // x0 as divisor
        send(UNIT_MULDIV, MD_REMU, 5'd27, 5'd20, 5'd0, 1'b0, '0);
        drain();
    endtask

    task test_mul_then_alu;
        test_name = "mul_then_alu";
        send(UNIT_ALU, ALU_ADD, 5'd14, 5'd0, 5'd0, 1'b1, $random(seed));
        send(UNIT_ALU, ALU_ADD, 5'd15, 5'd0, 5'd0, 1'b1, $random(seed));
        drain();
        send(UNIT_MULDIV, MD_MUL, 5'd16, 5'd14, 5'd15, 1'b0, '0);
        send(UNIT_ALU, ALU_ADD, 5'd17, 5'd14, 5'd0, 1'b1, 32'd7); // done long before the mul
        send(UNIT_ALU, ALU_ADD, 5'd18, 5'd16, 5'd17, 1'b0, '0);
        drain();
    endtask

    task test_burst;
        unit_e     u;
        logic [2:0] op;
        reg_addr_t rd;
        int        stalls_before;
        test_name = "burst";
        stalls_before = stalls;
        for (int i = 0; i < 12; i++) begin
            u  = (i % 3 == 1) ? UNIT_MULDIV : UNIT_ALU;
            op = (u == UNIT_ALU) ? 3'(i % 8) : 3'(i % 4);
            rd = (i % 2 == 0) ? 5'd5 : ((i == 7) ? 5'd0 : reg_addr_t'(6 + i)); // x5 WAW
            send(u, op, rd, (i == 0) ? 5'd1 : 5'd5, 5'd2, (i % 4) == 3, $random(seed));
        end
        send(UNIT_ALU, ALU_ADD, 5'd30, 5'd5, 5'd0, 1'b1, '0);  // newest x5
        send(UNIT_ALU, ALU_OR, 5'd31, 5'd0, 5'd0, 1'b0, '0);
        drain();
        if (stalls == stalls_before) begin
            errors++;
            $display("burst: dispatch_ready never dropped during the burst");
        end
    endtask

    initial begin
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        errors = 0;
        commits = 0;
        stalls = 0;
        cycles = 0;
        seed = 32'h50137b0b;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!dispatch_ready || commit.valid) begin
            errors++;
            $display("after reset: dispatch_ready is low or commit is already valid");
        end
        test_alu_imm();
        test_dep_chain();
        test_muldiv();
        test_mul_then_alu();
        test_burst();
        repeat (5) @(negedge clk); // catch stray commits
        $display("commits: %0d, errors: %0d", commits, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  core_pkg::tag_t    issue_tag,
    input  core_pkg::word_t   issue_a,
    input  core_pkg::word_t   issue_b,
    input  core_pkg::alu_op_e issue_op,
    input  logic              result_grant,
    output logic              unit_ready,
    output logic              result_req,
    output core_pkg::tag_t    result_tag,
    output core_pkg::word_t   result_value
);
    import core_pkg::*;

    word_t res;

    always_comb begin
        case (issue_op)
            ALU_ADD:  res = issue_a + issue_b;
            ALU_SUB:  res = issue_a - issue_b;
            ALU_AND:  res = issue_a & issue_b;
            ALU_OR:   res = issue_a | issue_b;
            ALU_XOR:  res = issue_a ^ issue_b;
            ALU_SLL:  res = issue_a << issue_b[4:0];
            ALU_SRL:  res = issue_a >> issue_b[4:0];
            default:  res = word_t'(issue_a < issue_b); // sltu
        endcase
    end

    // free again in the cycle the bus takes the result
    assign unit_ready = !result_req || result_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_req <= 1'b0;
        end else if (issue_valid) begin
            result_req <= 1'b1;
        end else if (result_grant) begin
            result_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result_tag   <= issue_tag;
            result_value <= res;
        end
    end

endmodule

// File: verilog/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic            alu_req,
    input  core_pkg::tag_t  alu_tag,
    input  core_pkg::word_t alu_value,
    input  logic            muldiv_req,
    input  core_pkg::tag_t  muldiv_tag,
    input  core_pkg::word_t muldiv_value,
    output logic            alu_grant,
    output logic            muldiv_grant,
    output core_pkg::cdb_t  cdb
);
    import core_pkg::*;

    // long ops first, the ALU holds its result meanwhile
    assign muldiv_grant = muldiv_req;
    assign alu_grant    = alu_req && !muldiv_req;

    always_comb begin
        cdb.valid = alu_req || muldiv_req;
        if (muldiv_req) begin
            cdb.tag   = muldiv_tag;
            cdb.value = muldiv_value;
        end else begin
            cdb.tag   = alu_tag;
            cdb.value = alu_value;
        end
    end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int TAG_W = 3;
    localparam int ROB_DEPTH = 1 << TAG_W;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MULDIV
    } unit_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLTU
    } alu_op_e;

    // all unsigned
    typedef enum logic [1:0] {
        MD_MUL,
        MD_MULHU,
        MD_DIVU,
        MD_REMU
    } muldiv_op_e;

    typedef struct packed {
        unit_e     unit;
        logic [2:0] op;     // muldiv uses [1:0]
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        word_t     imm;
    } dispatch_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;     // producer while not ready
        word_t value;
    } operand_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } commit_t;

endpackage

// File: verilog/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  core_pkg::tag_t       issue_tag,
    input  core_pkg::word_t      issue_a,
    input  core_pkg::word_t      issue_b,
    input  core_pkg::muldiv_op_e issue_op,
    input  logic                 result_grant,
    output logic                 unit_ready,
    output logic                 result_req,
    output core_pkg::tag_t       result_tag,
    output core_pkg::word_t      result_value
);
    import core_pkg::*;

    muldiv_op_e  op_q;
    logic        busy;
    logic [5:0]  step;
    word_t       hi;     // upper product / remainder
    word_t       lo;     // lower product / quotient
    word_t       mcand;  // multiplicand or divisor
    logic [32:0] mul_sum;
    logic [32:0] div_shift;
    logic [33:0] div_diff;
    logic        is_div;

    assign is_div    = op_q inside {MD_DIVU, MD_REMU};
    assign mul_sum   = {1'b0, hi} + (lo[0] ? {1'b0, mcand} : 33'd0);
    assign div_shift = {hi, lo[31]};
    assign div_diff  = {1'b0, div_shift} - {2'b0, mcand};

    assign unit_ready = !busy && (!result_req || result_grant);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            step       <= '0;
            result_req <= 1'b0;
        end else begin
            if (result_grant) begin
                result_req <= 1'b0;
            end
            if (issue_valid) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy && step == 6'd32) begin
                busy       <= 1'b0;
                result_req <= 1'b1;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_q       <= issue_op;
            result_tag <= issue_tag;
            hi         <= '0;
            lo         <= issue_op[1] ? issue_a : issue_b;
            mcand      <= issue_op[1] ? issue_b : issue_a;
        end else if (busy && step != 6'd32) begin
            if (is_div) begin
                // restoring step; a zero divisor leaves all ones and the dividend
                hi <= div_diff[33] ? div_shift[31:0] : div_diff[31:0];
                lo <= {lo[30:0], !div_diff[33]};
            end else begin
                hi <= mul_sum[32:1];
                lo <= {mul_sum[0], lo[31:1]};
            end
        end
        if (busy && step == 6'd32) begin
            result_value <= (op_q == MD_MUL || op_q == MD_DIVU) ? lo : hi;
        end
    end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
    parameter int ALU_RS_DEPTH    = 4,
    parameter int MULDIV_RS_DEPTH = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  core_pkg::dispatch_t dispatch,
    output logic                dispatch_ready,
    output core_pkg::commit_t   commit
);
    import core_pkg::*;

    logic       rs1_busy, rs2_busy;
    tag_t       rs1_tag, rs2_tag;
    word_t      rs1_value, rs2_value;
    logic       alloc_valid;
    tag_t       alloc_tag;
    tag_t       commit_tag;
    operand_t   src_a, src_b;
    logic       alu_rs_write, muldiv_rs_write;
    logic       alu_rs_full, muldiv_rs_full;
    cdb_t       cdb;

    logic       alu_issue, alu_ready, alu_req, alu_grant;
    tag_t       alu_issue_tag, alu_tag;
    word_t      alu_a, alu_b, alu_value;
    alu_op_e    alu_op;

    logic       md_issue, md_ready, md_req, md_grant;
    tag_t       md_issue_tag, md_tag;
    word_t      md_a, md_b, md_value;
    muldiv_op_e md_op;

    rename_table u_rename_table (
        .clk(clk), .rst(rst),
        .rs1(dispatch.rs1), .rs2(dispatch.rs2),
        .alloc_valid(alloc_valid), .alloc_rd(dispatch.rd), .alloc_tag(alloc_tag),
        .commit(commit), .commit_tag(commit_tag),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag), .rs1_value(rs1_value),
        .rs2_busy(rs2_busy), .rs2_tag(rs2_tag), .rs2_value(rs2_value)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .alu_rs_full(alu_rs_full), .muldiv_rs_full(muldiv_rs_full),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag), .rs1_value(rs1_value),
        .rs2_busy(rs2_busy), .rs2_tag(rs2_tag), .rs2_value(rs2_value),
        .cdb(cdb), .dispatch_ready(dispatch_ready),
        .alu_rs_write(alu_rs_write), .muldiv_rs_write(muldiv_rs_write),
        .alloc_tag(alloc_tag), .alloc_valid(alloc_valid),
        .src_a(src_a), .src_b(src_b), .commit(commit), .commit_tag(commit_tag)
    );

    reservation_station #(.DEPTH(ALU_RS_DEPTH), .payload_t(alu_op_e)) u_alu_rs (
        .clk(clk), .rst(rst), .write(alu_rs_write), .tag(alloc_tag),
        .src_a(src_a), .src_b(src_b), .op(alu_op_e'(dispatch.op)),
        .cdb(cdb), .unit_ready(alu_ready), .full(alu_rs_full),
        .issue_valid(alu_issue), .issue_tag(alu_issue_tag),
        .issue_a(alu_a), .issue_b(alu_b), .issue_op(alu_op)
    );

    reservation_station #(.DEPTH(MULDIV_RS_DEPTH), .payload_t(muldiv_op_e)) u_muldiv_rs (
        .clk(clk), .rst(rst), .write(muldiv_rs_write), .tag(alloc_tag),
        .src_a(src_a), .src_b(src_b), .op(muldiv_op_e'(dispatch.op[1:0])),
        .cdb(cdb), .unit_ready(md_ready), .full(muldiv_rs_full),
        .issue_valid(md_issue), .issue_tag(md_issue_tag),
        .issue_a(md_a), .issue_b(md_b), .issue_op(md_op)
    );

    alu_unit u_alu_unit (
        .clk(clk), .rst(rst), .issue_valid(alu_issue), .issue_tag(alu_issue_tag),
        .issue_a(alu_a), .issue_b(alu_b), .issue_op(alu_op), .result_grant(alu_grant),
        .unit_ready(alu_ready), .result_req(alu_req),
        .result_tag(alu_tag), .result_value(alu_value)
    );

    muldiv_unit u_muldiv_unit (
        .clk(clk), .rst(rst), .issue_valid(md_issue), .issue_tag(md_issue_tag),
        .issue_a(md_a), .issue_b(md_b), .issue_op(md_op), .result_grant(md_grant),
        .unit_ready(md_ready), .result_req(md_req),
        .result_tag(md_tag), .result_value(md_value)
    );

    cdb_arbiter u_cdb_arbiter (
        .alu_req(alu_req), .alu_tag(alu_tag), .alu_value(alu_value),
        .muldiv_req(md_req), .muldiv_tag(md_tag), .muldiv_value(md_value),
        .alu_grant(alu_grant), .muldiv_grant(md_grant), .cdb(cdb)
    );

endmodule

// File: verilog/rename_table.sv
`timescale 1ns/100ps

module rename_table (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                alloc_valid,
    input  core_pkg::reg_addr_t alloc_rd,
    input  core_pkg::tag_t      alloc_tag,
    input  core_pkg::commit_t   commit,
    input  core_pkg::tag_t      commit_tag,
    output logic                rs1_busy,
    output core_pkg::tag_t      rs1_tag,
    output core_pkg::word_t     rs1_value,
    output logic                rs2_busy,
    output core_pkg::tag_t      rs2_tag,
    output core_pkg::word_t     rs2_value
);
    import core_pkg::*;

    word_t       regs [32];
    logic [31:0] busy;
    tag_t        pend [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                // only the newest writer releases the register
                if (pend[commit.rd] == commit_tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            if (alloc_valid) begin // wins over a same-cycle clear
                busy[alloc_rd] <= 1'b1;
                pend[alloc_rd] <= alloc_tag;
            end
        end
    end

    assign rs1_busy  = busy[rs1];
    assign rs1_tag   = pend[rs1];
    assign rs1_value = regs[rs1]; // x0 never written
    assign rs2_busy  = busy[rs2];
    assign rs2_tag   = pend[rs2];
    assign rs2_value = regs[rs2];

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  core_pkg::dispatch_t dispatch,
    input  logic                alu_rs_full,
    input  logic                muldiv_rs_full,
    input  logic                rs1_busy,
    input  core_pkg::tag_t      rs1_tag,
    input  core_pkg::word_t     rs1_value,
    input  logic                rs2_busy,
    input  core_pkg::tag_t      rs2_tag,
    input  core_pkg::word_t     rs2_value,
    input  core_pkg::cdb_t      cdb,
    output logic                dispatch_ready,
    output logic                alu_rs_write,
    output logic                muldiv_rs_write,
    output core_pkg::tag_t      alloc_tag,
    output logic                alloc_valid,
    output core_pkg::operand_t  src_a,
    output core_pkg::operand_t  src_b,
    output core_pkg::commit_t   commit,
    output core_pkg::tag_t      commit_tag
);
    import core_pkg::*;

    tag_t                 head;
    tag_t                 tail;
    logic [TAG_W:0]       count;
    logic [ROB_DEPTH-1:0] done;
    reg_addr_t            rob_rd [ROB_DEPTH];
    word_t                rob_val [ROB_DEPTH];
    logic                 sel_full;
    logic                 accept;
    logic                 retire;

    // source lookup: register file, finished entry, then the bus
    function automatic operand_t resolve(input logic busy, input tag_t tag, input word_t arch,
                                         input logic rob_done, input word_t rob_value,
                                         input cdb_t bus);
        operand_t r;
        r.ready = 1'b1;
        r.tag   = tag;
        r.value = arch;
        if (busy) begin
            if (rob_done) begin
                r.value = rob_value;
            end else if (bus.valid && bus.tag == tag) begin
                r.value = bus.value;
            end else begin
                r.ready = 1'b0;
            end
        end
        return r;
    endfunction

    assign sel_full = (dispatch.unit == UNIT_ALU) ? alu_rs_full : muldiv_rs_full;
    assign dispatch_ready = (count != (TAG_W+1)'(ROB_DEPTH)) && !sel_full;
    assign accept = dispatch_valid && dispatch_ready;
    assign retire = (count != '0) && done[head];

    assign alu_rs_write    = accept && dispatch.unit == UNIT_ALU;
    assign muldiv_rs_write = accept && dispatch.unit == UNIT_MULDIV;
    assign alloc_tag       = tail;
    assign alloc_valid     = accept && dispatch.rd != '0;

    assign src_a = resolve(rs1_busy, rs1_tag, rs1_value, done[rs1_tag], rob_val[rs1_tag], cdb);
    assign src_b = dispatch.use_imm ? operand_t'{ready: 1'b1, tag: '0, value: dispatch.imm}
                 : resolve(rs2_busy, rs2_tag, rs2_value, done[rs2_tag], rob_val[rs2_tag], cdb);

    assign commit     = '{valid: retire, rd: rob_rd[head], value: rob_val[head]};
    assign commit_tag = head;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (accept) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (TAG_W+1)'(accept) - (TAG_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rob_rd[tail] <= dispatch.rd;
        end
        if (cdb.valid) begin
            rob_val[cdb.tag] <= cdb.value;
        end
    end

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/100ps

module reservation_station #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = core_pkg::alu_op_e
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               write,
    input  core_pkg::tag_t     tag,
    input  core_pkg::operand_t src_a,
    input  core_pkg::operand_t src_b,
    input  payload_t           op,
    input  core_pkg::cdb_t     cdb,
    input  logic               unit_ready,
    output logic               full,
    output logic               issue_valid,
    output core_pkg::tag_t     issue_tag,
    output core_pkg::word_t    issue_a,
    output core_pkg::word_t    issue_b,
    output payload_t           issue_op
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    typedef struct packed {
        tag_t     tag;
        operand_t a;
        operand_t b;
        payload_t op;
    } slot_t;

    slot_t            slots [DEPTH];
    logic [DEPTH-1:0] used;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] iss_idx;
    logic             have_issue;

    function automatic operand_t snoop(input operand_t o, input cdb_t bus);
        operand_t r;
        r = o;
        if (!o.ready && bus.valid && bus.tag == o.tag) begin
            r.ready = 1'b1;
            r.value = bus.value;
        end
        return r;
    endfunction

    // scan downwards so the lowest slot is picked
    always_comb begin
        free_idx   = '0;
        iss_idx    = '0;
        have_issue = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_idx = IDX_W'(i);
            end
            if (used[i] && slots[i].a.ready && slots[i].b.ready) begin
                iss_idx    = IDX_W'(i);
                have_issue = 1'b1;
            end
        end
    end

    assign full        = &used;
    assign issue_valid = have_issue && unit_ready;
    assign issue_tag   = slots[iss_idx].tag;
    assign issue_a     = slots[iss_idx].a.value;
    assign issue_b     = slots[iss_idx].b.value;
    assign issue_op    = slots[iss_idx].op;

    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
        end else begin
            if (issue_valid) begin
                used[iss_idx] <= 1'b0;
            end
            if (write) begin
                used[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i].a <= snoop(slots[i].a, cdb);
            slots[i].b <= snoop(slots[i].b, cdb);
        end
        if (write) begin // bus already bypassed by the ROB
            slots[free_idx] <= '{tag: tag, a: src_a, b: src_b, op: op};
        end
    end

endmodule
